// ==== sim.f ====
design/isa_pkg.sv
design/issue_pkg.sv
design/fust_if.sv
design/regfile.sv
design/dispatch_write.sv
design/fust_entry.sv
design/issue_select.sv
design/issue_top.sv
sim/issue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= issue_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/issue_tb.sv ====
// testbench for the issue stage with clock, reset, LFSR stimulus, execute-unit model,
// scoreboard model of expected operands and the directed and random checks
`default_nettype none

module issue_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FU  = 4;
    localparam int AGE_W   = 2;
    localparam int RST_CYC = 10;
    localparam int N_RAND  = 200;
    // random run plus the directed instructions of the later tests
    localparam int N_INSTR     = N_RAND + 4 + 4 + 3;
    localparam int TIMEOUT_CYC = N_INSTR * 40 + RST_CYC;

    logic             CLK;
    logic             nRST;
    logic             disp_req;
    isa_pkg::fu_e     disp_fu;
    isa_pkg::aluop_e  disp_op;
    isa_pkg::regsel_t disp_rd;
    isa_pkg::regsel_t disp_rs1;
    isa_pkg::regsel_t disp_rs2;
    logic             disp_ack;
    logic             wb_en   = 1'b0;
    isa_pkg::fu_e     wb_fu   = isa_pkg::FU_ALU;
    isa_pkg::regsel_t wb_rd   = '0;
    isa_pkg::word_t   wb_data = '0;
    logic             iss_req;
    logic             iss_ack = 1'b0;
    isa_pkg::fu_e     iss_fu;
    isa_pkg::aluop_e  iss_op;
    isa_pkg::regsel_t iss_rd;
    isa_pkg::word_t   iss_rdat1;
    isa_pkg::word_t   iss_rdat2;

    // scoreboard model written by the dispatcher
    int               last_wr [32];
    int               n_seq;
    int               n_accepted;
    int               n_acc_unit [NUM_FU];
    int               unit_seq   [NUM_FU];
    isa_pkg::aluop_e  exp_op     [NUM_FU];
    isa_pkg::regsel_t exp_rd     [NUM_FU];
    isa_pkg::word_t   exp_r1     [NUM_FU];
    isa_pkg::word_t   exp_r2     [NUM_FU];
    logic [31:0]      stim_lfsr = 32'h2669;
    logic             hold_ack  = 1'b0;
    int               err_main;
    int               n_pass;
    int               n_fail;

    // execute-unit model state
    logic [31:0]      exec_lfsr = 32'h2669;
    logic             exec_busy  [NUM_FU];
    int               exec_cnt   [NUM_FU];
    isa_pkg::regsel_t exec_rd    [NUM_FU];
    int               exec_seq   [NUM_FU];
    int               n_iss_unit [NUM_FU];
    int               wb_cnt     [NUM_FU];
    int               n_written;
    int               issued [$];
    logic             iss_seen;
    int               err_mon;

    issue_top #(.NUM_FU(NUM_FU), .AGE_W(AGE_W)) u_dut (
        .CLK       (CLK),
        .nRST      (nRST),
        .disp_req  (disp_req),
        .disp_fu   (disp_fu),
        .disp_op   (disp_op),
        .disp_rd   (disp_rd),
        .disp_rs1  (disp_rs1),
        .disp_rs2  (disp_rs2),
        .disp_ack  (disp_ack),
        .wb_en     (wb_en),
        .wb_fu     (wb_fu),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .iss_req   (iss_req),
        .iss_ack   (iss_ack),
        .iss_fu    (iss_fu),
        .iss_op    (iss_op),
        .iss_rd    (iss_rd),
        .iss_rdat1 (iss_rdat1),
        .iss_rdat2 (iss_rdat2)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] take_bits(inout logic [31:0] s, input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = s[31] ^ s[21] ^ s[1] ^ s[0];
            s  = {s[30:0], fb};
            v  = {v[30:0], fb};
        end
        return v;
    endfunction

    // value an execute unit returns for a given dispatch sequence number
    function automatic isa_pkg::word_t result_of(input int seq);
        return 32'h5A00_0001 + 32'(seq) * 32'h0001_0101;
    endfunction

    function automatic isa_pkg::word_t model_value(input isa_pkg::regsel_t r);
        if (r == '0 || last_wr[r] < 0) begin
            return '0;
        end
        return result_of(last_wr[r]);
    endfunction

    function automatic int find_pos(input int seq);
        for (int k = 0; k < issued.size(); k++) begin
            if (issued[k] == seq) begin
                return k;
            end
        end
        return -1;
    endfunction

    task automatic report_mismatch(input string name, input isa_pkg::word_t got,
                                   input isa_pkg::word_t exp);
        $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
    endtask

    task automatic close_test(input string name, input int err0);
        int errs;
        errs = err_main + err_mon - err0;
        if (errs == 0) begin
            n_pass++;
            $display("test %s: PASS", name);
        end else begin
            n_fail++;
            $display("test %s: FAIL with %0d errors", name, errs);
        end
    endtask

    // four-phase dispatch that records the model once ack is seen
    task automatic dispatch(input isa_pkg::fu_e fu, input isa_pkg::aluop_e op,
                            input isa_pkg::regsel_t rd, rs1, rs2, output int seq);
        int u;
        u   = int'(fu);
        seq = n_seq;
        n_seq++;
        @(posedge CLK);
        disp_req <= 1'b1;
        disp_fu  <= fu;
        disp_op  <= op;
        disp_rd  <= rd;
        disp_rs1 <= rs1;
        disp_rs2 <= rs2;
        @(posedge CLK);
        while (!disp_ack) @(posedge CLK);
        unit_seq[u] = seq;
        exp_op[u]   = op;
        exp_rd[u]   = rd;
        exp_r1[u]   = model_value(rs1);
        exp_r2[u]   = model_value(rs2);
        n_acc_unit[u]++;
        n_accepted++;
        if (rd != '0) begin
            last_wr[rd] = seq;
        end
        disp_req <= 1'b0;
        @(posedge CLK);
        while (disp_ack) @(posedge CLK);
    endtask

    task automatic drain();
        @(posedge CLK);
        while (n_written != n_accepted) @(posedge CLK);
    endtask

    // execute units, issue ack responder and issue checker
    always @(posedge CLK) begin : exec_model
        int          u;
        logic        picked;
        logic [31:0] v;
        if (!nRST) begin
            wb_en     <= 1'b0;
            iss_ack   <= 1'b0;
            n_written <= 0;
            iss_seen  = 1'b0;
            for (u = 0; u < NUM_FU; u++) begin
                exec_busy[u]  = 1'b0;
                exec_cnt[u]   = 0;
                n_iss_unit[u] = 0;
                wb_cnt[u]    <= 0;
            end
        end else begin
            // the DUT consumes the strobe at this edge
            if (wb_en) begin
                wb_cnt[int'(wb_fu)] <= wb_cnt[int'(wb_fu)] + 1;
                n_written           <= n_written + 1;
            end
            wb_en <= 1'b0;
            for (u = 0; u < NUM_FU; u++) begin
                if (exec_busy[u] && exec_cnt[u] > 0) begin
                    exec_cnt[u]--;
                end
            end
            // single writeback port where the lowest finished unit goes first
            picked = 1'b0;
            for (u = 0; u < NUM_FU; u++) begin
                if (!picked && exec_busy[u] && exec_cnt[u] == 0) begin
                    picked       = 1'b1;
                    exec_busy[u] = 1'b0;
                    wb_en       <= 1'b1;
                    wb_fu       <= isa_pkg::fu_e'(2'(u));
                    wb_rd       <= exec_rd[u];
                    wb_data     <= result_of(exec_seq[u]);
                end
            end
            if (iss_req && !iss_seen) begin
                iss_seen = 1'b1;
                u        = int'(iss_fu);
                if (n_acc_unit[u] <= n_iss_unit[u]) begin
                    $display("ERROR t=%0t issue from unit %0d with no instruction waiting",
                             $time, u);
                    err_mon++;
                end else begin
                    n_iss_unit[u]++;
                    issued.push_back(unit_seq[u]);
                    if (iss_op !== exp_op[u]) begin
                        report_mismatch("iss_op", 32'(iss_op), 32'(exp_op[u]));
                        err_mon++;
                    end
                    if (iss_rd !== exp_rd[u]) begin
                        report_mismatch("iss_rd", 32'(iss_rd), 32'(exp_rd[u]));
                        err_mon++;
                    end
                    if (iss_rdat1 !== exp_r1[u]) begin
                        report_mismatch("iss_rdat1", iss_rdat1, exp_r1[u]);
                        err_mon++;
                    end
                    if (iss_rdat2 !== exp_r2[u]) begin
                        report_mismatch("iss_rdat2", iss_rdat2, exp_r2[u]);
                        err_mon++;
                    end
                end
            end else if (!iss_req) begin
                iss_seen = 1'b0;
            end
            // execution starts when the issue is acknowledged
            if (iss_req && !iss_ack && !hold_ack) begin
                iss_ack <= 1'b1;
                u = int'(iss_fu);
                v = take_bits(exec_lfsr, 3);
                exec_busy[u] = 1'b1;
                exec_cnt[u]  = int'(v % 32'd6) + 1;
                exec_rd[u]   = iss_rd;
                exec_seq[u]  = unit_seq[u];
            end else if (!iss_req && iss_ack) begin
                iss_ack <= 1'b0;
            end
        end
    end

    initial begin : stimulus
        int          seq_a;
        int          seq_b;
        int          err0;
        int          base;
        int          start;
        int          pos_x;
        int          pos_y;
        int          seqs [4];
        logic [31:0] v;
        nRST     = 1'b0;
        disp_req = 1'b0;
        disp_fu  = isa_pkg::FU_ALU;
        disp_op  = isa_pkg::OP_ADD;
        disp_rd  = '0;
        disp_rs1 = '0;
        disp_rs2 = '0;
        for (int r = 0; r < 32; r++) begin
            last_wr[r] = -1;
        end

        repeat (RST_CYC) @(posedge CLK);
        nRST <= 1'b1;
        repeat (2) @(posedge CLK);
        err0 = err_main + err_mon;
        if (iss_req !== 1'b0) begin
            report_mismatch("iss_req", 32'(iss_req), 32'd0);
            err_main++;
        end
        if (disp_ack !== 1'b0) begin
            report_mismatch("disp_ack", 32'(disp_ack), 32'd0);
            err_main++;
        end
        if (iss_rdat1 !== '0) begin
            report_mismatch("iss_rdat1", iss_rdat1, 32'd0);
            err_main++;
        end
        if (iss_rdat2 !== '0) begin
            report_mismatch("iss_rdat2", iss_rdat2, 32'd0);
            err_main++;
        end
        if (iss_rd !== '0) begin
            report_mismatch("iss_rd", 32'(iss_rd), 32'd0);
            err_main++;
        end
        close_test("reset", err0);

        // small register range so dependencies are frequent
        err0 = err_main + err_mon;
        for (int i = 0; i < N_RAND; i++) begin
            v = take_bits(stim_lfsr, 14);
            dispatch(isa_pkg::fu_e'(v[13:12]), isa_pkg::aluop_e'(v[11:9]),
                     {2'b00, v[8:6]}, {2'b00, v[5:3]}, {2'b00, v[2:0]}, seq_a);
        end
        drain();
        close_test("random operands", err0);

        // first one is picked at once and the rest queue up behind the held ack
        err0     = err_main + err_mon;
        start    = issued.size();
        hold_ack <= 1'b1;
        dispatch(isa_pkg::FU_MUL, isa_pkg::OP_ADD, 5'd20, 5'd0, 5'd0, seqs[0]);
        dispatch(isa_pkg::FU_BRANCH, isa_pkg::OP_SUB, 5'd21, 5'd0, 5'd0, seqs[1]);
        dispatch(isa_pkg::FU_LDST, isa_pkg::OP_LD, 5'd22, 5'd0, 5'd0, seqs[2]);
        dispatch(isa_pkg::FU_ALU, isa_pkg::OP_XOR, 5'd23, 5'd0, 5'd0, seqs[3]);
        hold_ack <= 1'b0;
        drain();
        for (int k = 0; k < 4; k++) begin
            if (issued[start + k] != seqs[k]) begin
                report_mismatch("issue order", 32'(issued[start + k]), 32'(seqs[k]));
                err_main++;
            end
        end
        close_test("oldest first", err0);

        // busy entry first and then an in-flight destination
        err0     = err_main + err_mon;
        hold_ack <= 1'b1;
        dispatch(isa_pkg::FU_ALU, isa_pkg::OP_ADD, 5'd5, 5'd0, 5'd0, seq_a);
        base = wb_cnt[0];
        fork
            begin
                dispatch(isa_pkg::FU_ALU, isa_pkg::OP_SUB, 5'd6, 5'd1, 5'd2, seq_b);
                if (wb_cnt[0] == base) begin
                    $display("dispatch to a busy unit was accepted before its writeback");
                    err_main++;
                end
            end
            begin
                repeat (20) @(posedge CLK);
                hold_ack <= 1'b0;
            end
        join
        drain();
        hold_ack <= 1'b1;
        dispatch(isa_pkg::FU_LDST, isa_pkg::OP_LD, 5'd7, 5'd0, 5'd0, seq_a);
        base = wb_cnt[1];
        fork
            begin
                dispatch(isa_pkg::FU_MUL, isa_pkg::OP_ADD, 5'd7, 5'd3, 5'd4, seq_b);
                if (wb_cnt[1] == base) begin
                    $display("dispatch with an in-flight destination was accepted early");
                    err_main++;
                end
            end
            begin
                repeat (20) @(posedge CLK);
                hold_ack <= 1'b0;
            end
        join
        drain();
        close_test("back-pressure", err0);

        // reader of r10 waits on a held producer while a younger writer of r10 is ready
        err0     = err_main + err_mon;
        hold_ack <= 1'b1;
        dispatch(isa_pkg::FU_MUL, isa_pkg::OP_ADD, 5'd9, 5'd0, 5'd0, seq_a);
        dispatch(isa_pkg::FU_ALU, isa_pkg::OP_AND, 5'd11, 5'd9, 5'd10, seq_a);
        dispatch(isa_pkg::FU_LDST, isa_pkg::OP_LD, 5'd10, 5'd0, 5'd0, seq_b);
        repeat (10) @(posedge CLK);
        hold_ack <= 1'b0;
        drain();
        pos_x = find_pos(seq_a);
        pos_y = find_pos(seq_b);
        if (pos_x < 0 || pos_y < 0 || pos_y < pos_x) begin
            $display("older reader of r10 did not issue ahead of the younger writer");
            err_main++;
        end
        close_test("write-after-read", err0);

        $display("%0d tests run, %0d passed, %0d failed, %0d issues checked",
                 n_pass + n_fail, n_pass, n_fail, issued.size());
        if (n_fail == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYC) @(posedge CLK);
        $display("watchdog expired after %0d cycles, the stage stopped responding",
                 TIMEOUT_CYC);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/issue_top.sv ====
// issue stage top: register file, dispatch writer, status-table entries, selector
`default_nettype none

module issue_top #(
    parameter int NUM_FU = 4,
    parameter int AGE_W  = 2
) (
    input  logic             CLK,
    input  logic             nRST,
    // dispatch
    input  logic             disp_req,
    input  isa_pkg::fu_e     disp_fu,
    input  isa_pkg::aluop_e  disp_op,
    input  isa_pkg::regsel_t disp_rd,
    input  isa_pkg::regsel_t disp_rs1,
    input  isa_pkg::regsel_t disp_rs2,
    output logic             disp_ack,
    // writeback strobe
    input  logic             wb_en,
    input  isa_pkg::fu_e     wb_fu,
    input  isa_pkg::regsel_t wb_rd,
    input  isa_pkg::word_t   wb_data,
    // issue
    output logic             iss_req,
    input  logic             iss_ack,
    output isa_pkg::fu_e     iss_fu,
    output isa_pkg::aluop_e  iss_op,
    output isa_pkg::regsel_t iss_rd,
    output isa_pkg::word_t   iss_rdat1,
    output isa_pkg::word_t   iss_rdat2
);

    isa_pkg::regsel_t rsel1;
    isa_pkg::regsel_t rsel2;
    isa_pkg::word_t   rdat1;
    isa_pkg::word_t   rdat2;

    fust_if #(.NUM_FU(NUM_FU), .AGE_W(AGE_W)) fif ();

    regfile u_rf (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (wb_en),
        .wsel  (wb_rd),
        .wdata (wb_data),
        .rsel1 (rsel1),
        .rsel2 (rsel2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    dispatch_write #(.NUM_FU(NUM_FU)) u_dw (
        .CLK      (CLK),
        .nRST     (nRST),
        .disp_req (disp_req),
        .disp_fu  (disp_fu),
        .disp_op  (disp_op),
        .disp_rd  (disp_rd),
        .disp_rs1 (disp_rs1),
        .disp_rs2 (disp_rs2),
        .disp_ack (disp_ack),
        .wb_en    (wb_en),
        .wb_fu    (wb_fu),
        .wb_rd    (wb_rd),
        .fw       (fif.wr)
    );

    // one entry per functional unit
    for (genvar i = 0; i < NUM_FU; i++) begin : g_ent
        fust_entry #(.IDX(i), .AGE_W(AGE_W)) u_ent (
            .CLK   (CLK),
            .nRST  (nRST),
            .wb_en (wb_en),
            .wb_fu (wb_fu),
            .fe    (fif.ent)
        );
    end

    issue_select #(.NUM_FU(NUM_FU), .AGE_W(AGE_W)) u_sel (
        .CLK       (CLK),
        .nRST      (nRST),
        .fs        (fif.sel),
        .rsel1     (rsel1),
        .rsel2     (rsel2),
        .rdat1     (rdat1),
        .rdat2     (rdat2),
        .iss_req   (iss_req),
        .iss_ack   (iss_ack),
        .iss_fu    (iss_fu),
        .iss_op    (iss_op),
        .iss_rd    (iss_rd),
        .iss_rdat1 (iss_rdat1),
        .iss_rdat2 (iss_rdat2)
    );

endmodule

`default_nettype wire

// ==== design/issue_select.sv ====
// oldest-first issue selection with war hold, operand read and issue handshake
`default_nettype none

module issue_select #(
    parameter int NUM_FU = 4,
    parameter int AGE_W  = 2
) (
    input  logic             CLK,
    input  logic             nRST,
    fust_if.sel              fs,
    output isa_pkg::regsel_t rsel1,
    output isa_pkg::regsel_t rsel2,
    input  isa_pkg::word_t   rdat1,
    input  isa_pkg::word_t   rdat2,
    output logic             iss_req,
    input  logic             iss_ack,
    output isa_pkg::fu_e     iss_fu,
    output isa_pkg::aluop_e  iss_op,
    output isa_pkg::regsel_t iss_rd,
    output isa_pkg::word_t   iss_rdat1,
    output isa_pkg::word_t   iss_rdat2
);

    localparam int IDX_W = $clog2(NUM_FU);

    typedef enum logic [1:0] {
        SEL_IDLE,
        SEL_REQ,
        SEL_ACK_LOW
    } sel_state_e;

    sel_state_e        sel_st;
    logic [NUM_FU-1:0] elig;
    logic              found;
    logic [IDX_W-1:0]  pick;
    logic [AGE_W-1:0]  pick_age;

    // hold a ready entry while an older waiting one still reads its rd
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            elig[i] = fs.state[i] == issue_pkg::FUST_RDY;
            for (int j = 0; j < NUM_FU; j++) begin
                if (j != i && fs.row_out[i].rd != '0
                        && (fs.state[j] == issue_pkg::FUST_WAIT
                            || fs.state[j] == issue_pkg::FUST_RDY)
                        && fs.age[j] > fs.age[i]
                        && (fs.row_out[j].rs1 == fs.row_out[i].rd
                            || fs.row_out[j].rs2 == fs.row_out[i].rd)) begin
                    elig[i] = 1'b0;
                end
            end
        end
    end

    // largest age wins and a strict compare keeps the lowest index on a tie
    always_comb begin
        found    = 1'b0;
        pick     = '0;
        pick_age = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (elig[i] && (!found || fs.age[i] > pick_age)) begin
                found    = 1'b1;
                pick     = IDX_W'(i);
                pick_age = fs.age[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            fs.go[i] = (sel_st == SEL_IDLE) && found && (pick == IDX_W'(i));
        end
    end

    assign rsel1   = fs.row_out[pick].rs1;
    assign rsel2   = fs.row_out[pick].rs2;
    assign iss_req = (sel_st == SEL_REQ);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sel_st    <= SEL_IDLE;
            iss_fu    <= isa_pkg::FU_ALU;
            iss_op    <= isa_pkg::OP_ADD;
            iss_rd    <= '0;
            iss_rdat1 <= '0;
            iss_rdat2 <= '0;
        end else begin
            case (sel_st)
                SEL_IDLE: begin
                    if (found) begin
                        sel_st    <= SEL_REQ;
                        iss_fu    <= isa_pkg::fu_e'(pick);
                        iss_op    <= fs.row_out[pick].op;
                        iss_rd    <= fs.row_out[pick].rd;
                        iss_rdat1 <= rdat1;
                        iss_rdat2 <= rdat2;
                    end
                end
                SEL_REQ: begin
                    if (iss_ack) begin
                        sel_st <= SEL_ACK_LOW;
                    end
                end
                SEL_ACK_LOW: begin
                    // wait for ack to drop before the next request
                    if (!iss_ack) begin
                        sel_st <= SEL_IDLE;
                    end
                end
                default: sel_st <= SEL_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/fust_entry.sv ====
// one status-table entry with state machine, row with tags, age rank and writeback snoop
`default_nettype none

module fust_entry #(
    parameter int IDX   = 0,
    parameter int AGE_W = 2
) (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         wb_en,
    input  isa_pkg::fu_e wb_fu,
    fust_if.ent          fe
);

    issue_pkg::fust_state_e state;
    issue_pkg::fust_row_t   row;
    logic [AGE_W-1:0]       age;
    issue_pkg::tag_t        wb_tag;
    logic                   own_wb;
    logic                   other_wr;
    logic                   younger_left;

    assign wb_tag   = {1'b0, wb_fu} + 3'd1;
    assign own_wb   = wb_en && (int'(wb_fu) == IDX);
    assign other_wr = (|fe.wen) && !fe.wen[IDX];

    // a younger live entry finishing moves this one down a rank
    // so ages stay a dense order over live entries and never wrap
    assign younger_left = wb_en && !own_wb
                       && fe.state[wb_fu] == issue_pkg::FUST_EX
                       && fe.age[wb_fu] < age;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= issue_pkg::FUST_EMPTY;
        end else begin
            case (state)
                issue_pkg::FUST_EMPTY: begin
                    if (fe.wen[IDX]) begin
                        state <= issue_pkg::FUST_WAIT;
                    end
                end
                issue_pkg::FUST_WAIT: begin
                    if (row.t1 == '0 && row.t2 == '0) begin
                        state <= issue_pkg::FUST_RDY;
                    end
                end
                issue_pkg::FUST_RDY: begin
                    if (fe.go[IDX]) begin
                        state <= issue_pkg::FUST_EX;
                    end
                end
                issue_pkg::FUST_EX: begin
                    if (own_wb) begin
                        state <= issue_pkg::FUST_EMPTY;
                    end
                end
                default: state <= issue_pkg::FUST_EMPTY;
            endcase
        end
    end

    // writeback of unit k clears tags equal to k+1
    always_ff @(posedge CLK) begin
        if (fe.wen[IDX]) begin
            row <= fe.row;
        end else begin
            if (wb_en && row.t1 == wb_tag) begin
                row.t1 <= '0;
            end
            if (wb_en && row.t2 == wb_tag) begin
                row.t2 <= '0;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            age <= '0;
        end else if (fe.wen[IDX]) begin
            age <= '0;
        end else if (state != issue_pkg::FUST_EMPTY) begin
            if (other_wr && !younger_left) begin
                age <= age + 1'b1;
            end else if (younger_left && !other_wr) begin
                age <= age - 1'b1;
            end
        end
    end

    assign fe.state[IDX]   = state;
    assign fe.age[IDX]     = age;
    assign fe.row_out[IDX] = row;

endmodule

`default_nettype wire

// ==== design/dispatch_write.sv ====
// dispatch handshake, register result status, source tag lookup and entry write
`default_nettype none

module dispatch_write #(
    parameter int NUM_FU = 4
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             disp_req,
    input  isa_pkg::fu_e     disp_fu,
    input  isa_pkg::aluop_e  disp_op,
    input  isa_pkg::regsel_t disp_rd,
    input  isa_pkg::regsel_t disp_rs1,
    input  isa_pkg::regsel_t disp_rs2,
    output logic             disp_ack,
    input  logic             wb_en,
    input  isa_pkg::fu_e     wb_fu,
    input  isa_pkg::regsel_t wb_rd,
    fust_if.wr               fw
);

    localparam int NREG = 2 ** isa_pkg::REG_W;

    // per register, tag of the unit that will write it
    issue_pkg::tag_t rstat [NREG];

    issue_pkg::tag_t wb_tag;
    issue_pkg::tag_t disp_tag;
    issue_pkg::tag_t t1;
    issue_pkg::tag_t t2;
    issue_pkg::tag_t trd;
    logic            accept;

    assign wb_tag   = {1'b0, wb_fu} + 3'd1;
    assign disp_tag = {1'b0, disp_fu} + 3'd1;

    // lookup sees a writeback in the same cycle as already done
    always_comb begin
        t1  = rstat[disp_rs1];
        t2  = rstat[disp_rs2];
        trd = rstat[disp_rd];
        if (wb_en && t1 == wb_tag) begin
            t1 = '0;
        end
        if (wb_en && t2 == wb_tag) begin
            t2 = '0;
        end
        if (wb_en && trd == wb_tag) begin
            trd = '0;
        end
    end

    // refuse on a busy entry or a pending writer of rd (waw)
    assign accept = disp_req && !disp_ack
                 && fw.state[disp_fu] == issue_pkg::FUST_EMPTY
                 && (disp_rd == '0 || trd == '0);

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            fw.wen[i] = accept && (int'(disp_fu) == i);
        end
        fw.row.op  = disp_op;
        fw.row.rd  = disp_rd;
        fw.row.rs1 = disp_rs1;
        fw.row.rs2 = disp_rs2;
        fw.row.t1  = t1;
        fw.row.t2  = t2;
    end

    // ack holds until the sender drops req
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            disp_ack <= 1'b0;
        end else if (accept) begin
            disp_ack <= 1'b1;
        end else if (!disp_req) begin
            disp_ack <= 1'b0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NREG; i++) begin
                rstat[i] <= '0;
            end
        end else begin
            // only clear if the status still names the finishing unit
            if (wb_en && rstat[wb_rd] == wb_tag) begin
                rstat[wb_rd] <= '0;
            end
            if (accept && disp_rd != '0) begin
                rstat[disp_rd] <= disp_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
// register file, two combinational read ports and one write port
`default_nettype none

module regfile (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             wen,
    input  isa_pkg::regsel_t wsel,
    input  isa_pkg::word_t   wdata,
    input  isa_pkg::regsel_t rsel1,
    input  isa_pkg::regsel_t rsel2,
    output isa_pkg::word_t   rdat1,
    output isa_pkg::word_t   rdat2
);

    localparam int NREG = 2 ** isa_pkg::REG_W;

    isa_pkg::word_t regs [NREG];

    // register 0 is never written so it reads as zero
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdata;
        end
    end

    assign rdat1 = regs[rsel1];
    assign rdat2 = regs[rsel2];

endmodule

`default_nettype wire

// ==== design/fust_if.sv ====
// status-table interface with row broadcast from dispatch, per-entry status and issue grants
`default_nettype none

interface fust_if #(
    parameter int NUM_FU = 4,
    parameter int AGE_W  = 2
);

    // dispatch side with one write enable per entry
    logic [NUM_FU-1:0]      wen;
    issue_pkg::fust_row_t   row;

    // each entry drives its own element
    issue_pkg::fust_state_e state   [NUM_FU];
    logic [AGE_W-1:0]       age     [NUM_FU];
    issue_pkg::fust_row_t   row_out [NUM_FU];

    // one-hot issue grant
    logic [NUM_FU-1:0]      go;

    modport wr  (output wen, row, input state);
    modport ent (input wen, row, go, output state, age, row_out);
    modport sel (input state, age, row_out, output go);

endinterface

`default_nettype wire

// ==== design/issue_pkg.sv ====
// status-table definitions: entry states, producer tags and the row type
`default_nettype none

package issue_pkg;

    typedef enum logic [1:0] {
        FUST_EMPTY = 2'd0,
        FUST_WAIT  = 2'd1,
        FUST_RDY   = 2'd2,
        FUST_EX    = 2'd3
    } fust_state_e;

    // zero means operand available, otherwise producing unit index plus one
    typedef logic [2:0] tag_t;

    // one dispatched instruction as held by an entry
    typedef struct packed {
        isa_pkg::aluop_e  op;
        isa_pkg::regsel_t rd;
        isa_pkg::regsel_t rs1;
        isa_pkg::regsel_t rs2;
        tag_t             t1;
        tag_t             t2;
    } fust_row_t;

endpackage

`default_nettype wire

// ==== design/isa_pkg.sv ====
// instruction-set definitions: register index, data word, unit kinds and opcodes
`default_nettype none

package isa_pkg;

    parameter int REG_W = 5;

    typedef logic [REG_W-1:0] regsel_t;
    typedef logic [31:0] word_t;

    // the value of a unit kind is also its status-table entry index
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_LDST   = 2'd1,
        FU_BRANCH = 2'd2,
        FU_MUL    = 2'd3
    } fu_e;

    // operation carried through to execute
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5,
        OP_LD  = 3'd6,
        OP_ST  = 3'd7
    } aluop_e;

endpackage

`default_nettype wire
